//--- Bender.yml
package:
  name: wb_subsys

sources:
  - include_dirs:
      - source
    files:
      - source/core_types_pkg.sv
      - source/lsu_types_pkg.sv
      - source/lsu_resp_if.sv
      - source/stage_reg.sv
      - source/wb_stage.sv
      - source/reg_file.sv
      - source/wb_subsys_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_wb_subsys.sv

//--- build.f
+incdir+source
source/core_types_pkg.sv
source/lsu_types_pkg.sv
source/lsu_resp_if.sv
source/stage_reg.sv
source/wb_stage.sv
source/reg_file.sv
source/wb_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_wb_subsys.sv

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock and power-on reset
module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset lets go just after a rising edge, at the same point where stimulus changes
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_wb_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// Directed tests for the write-back subsystem
module tb_wb_subsys;

  import lsu_types_pkg::*;

  // The tests need roughly 75 cycles with reset, so 400 leaves wide margin
  localparam int MAX_CYCLES  = 400;
  localparam int RETIRE_WAIT = 20;

  logic                clk, rst_n;
  logic                instr_valid, instr_ready, instr_rf_we, instr_lsu_en;
  logic                instr_xif_en, instr_last_op, kill, halt, halt_limited;
  logic [`RADDR_W-1:0] instr_rf_waddr, rf_raddr;
  logic [`XLEN-1:0]    instr_rf_wdata, lsu_rdata, xif_data, rf_rdata;
  logic                lsu_rvalid, lsu_wpt_match, lsu_req, xif_valid, xif_ready, xif_exc;
  mpu_status_e         lsu_mpu_status;
  logic                wb_valid, abort_op, data_stall, last_op;

  // Reference copy of the register file, updated only by the retirement rules
  logic [`XLEN-1:0]    exp_regs [`NREGS];
  logic [15:0]         lfsr_state = 16'd24;
  int                  errors = 0;
  int                  checks = 0;
  int                  cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  wb_subsys_top uut (
    .clk, .rst_n, .instr_valid_i(instr_valid), .instr_ready_o(instr_ready),
    .instr_rf_we_i(instr_rf_we), .instr_rf_waddr_i(instr_rf_waddr),
    .instr_rf_wdata_i(instr_rf_wdata), .instr_lsu_en_i(instr_lsu_en),
    .instr_xif_en_i(instr_xif_en), .instr_last_op_i(instr_last_op), .kill_i(kill),
    .halt_i(halt), .halt_limited_i(halt_limited), .lsu_rvalid_i(lsu_rvalid),
    .lsu_rdata_i(lsu_rdata), .lsu_mpu_status_i(lsu_mpu_status),
    .lsu_wpt_match_i(lsu_wpt_match), .lsu_req_o(lsu_req), .xif_valid_i(xif_valid),
    .xif_ready_o(xif_ready), .xif_data_i(xif_data), .xif_exc_i(xif_exc),
    .rf_raddr_i(rf_raddr), .rf_rdata_o(rf_rdata), .wb_valid_o(wb_valid),
    .abort_op_o(abort_op), .data_stall_o(data_stall), .last_op_o(last_op)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit that goes into the value
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // x0 has its own test, so random destinations avoid it
  function automatic logic [`RADDR_W-1:0] rand_addr();
    logic [`RADDR_W-1:0] a;
    a = `RADDR_W'(take_bits(`RADDR_W));
    return (a == '0) ? `RADDR_W'(1) : a;
  endfunction

  // Every task starts and ends 2 ns after a rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // The read port is combinational, so a short settle is enough
  task automatic check_reg(input logic [`RADDR_W-1:0] addr);
    rf_raddr = addr;
    #1;
    check_val($sformatf("rf_rdata_o[x%0d]", addr), rf_rdata, exp_regs[addr]);
  endtask

  // Hands one instruction to the EX/WB register and returns in its first WB cycle
  task automatic send_instr(input logic we, input logic [`RADDR_W-1:0] addr,
                            input logic [`XLEN-1:0] data, input logic lsu, input logic xif);
    instr_valid    = 1'b1;
    instr_rf_we    = we;
    instr_rf_waddr = addr;
    instr_rf_wdata = data;
    instr_lsu_en   = lsu;
    instr_xif_en   = xif;
    instr_last_op  = 1'b1;
    @(negedge clk);
    check_val("instr_ready_o", instr_ready, 1'b1);
    next_cycle();
    instr_valid = 1'b0;
  endtask

  // Returns at the falling edge of the retire cycle, with the cycles spent waiting
  task automatic wait_retire(output int cycles);
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (wb_valid) begin
        done = 1'b1;
      end else if (cycles == RETIRE_WAIT) begin
        errors++;
        $display("The WB instruction did not retire within %0d cycles", RETIRE_WAIT);
        cycles = -1;
        done   = 1'b1;
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic alu_write(input logic [`RADDR_W-1:0] addr, input logic [`XLEN-1:0] data);
    int cycles;
    send_instr(1'b1, addr, data, 1'b0, 1'b0);
    wait_retire(cycles);
    check_val("alu retire cycles", cycles, 0);
    check_val("last_op_o", last_op, 1'b1);
    check_val("abort_op_o", abort_op, 1'b0);
    next_cycle();
    // Writes to x0 leave it at zero
    if (addr != '0) begin
      exp_regs[addr] = data;
    end
    check_reg(addr);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_alu();
    check_val("instr_ready_o", instr_ready, 1'b1);
    check_val("wb_valid_o", wb_valid, 1'b0);
    check_val("xif_ready_o", xif_ready, 1'b1);
    repeat (6) begin
      alu_write(rand_addr(), take_bits(32));
    end
    alu_write('0, take_bits(32));
  endtask

  task automatic test_load();
    logic [`RADDR_W-1:0] addr;
    logic [`XLEN-1:0]    data;
    int                  cycles;
    addr = rand_addr();
    data = take_bits(32);
    send_instr(1'b1, addr, take_bits(32), 1'b1, 1'b0);
    repeat (2) begin
      @(negedge clk);
      check_val("data_stall_o", data_stall, 1'b1);
      check_val("wb_valid_o", wb_valid, 1'b0);
      check_val("lsu_req_o", lsu_req, 1'b1);
      next_cycle();
    end
    lsu_rvalid = 1'b1;
    lsu_rdata  = data;
    wait_retire(cycles);
    check_val("load retire cycles", cycles, 0);
    check_val("data_stall_o", data_stall, 1'b0);
    next_cycle();
    lsu_rvalid     = 1'b0;
    exp_regs[addr] = data;
    check_reg(addr);
    // Response during a halt must survive until the halt is released
    addr = rand_addr();
    data = take_bits(32);
    halt = 1'b1;
    send_instr(1'b1, addr, take_bits(32), 1'b1, 1'b0);
    lsu_rvalid = 1'b1;
    lsu_rdata  = data;
    next_cycle();
    lsu_rvalid = 1'b0;
    lsu_rdata  = take_bits(32);
    repeat (3) begin
      @(negedge clk);
      check_val("wb_valid_o", wb_valid, 1'b0);
      check_val("instr_ready_o", instr_ready, 1'b0);
      next_cycle();
    end
    halt = 1'b0;
    wait_retire(cycles);
    check_val("halted load retire cycles", cycles, 0);
    next_cycle();
    exp_regs[addr] = data;
    check_reg(addr);
  endtask

  // A faulting or watched load retires with abort and leaves the old value
  task automatic faulty_load(input mpu_status_e status, input logic wpt);
    logic [`RADDR_W-1:0] addr;
    int                  cycles;
    addr = rand_addr();
    alu_write(addr, take_bits(32));
    send_instr(1'b1, addr, take_bits(32), 1'b1, 1'b0);
    // Data lines carry junk while the request waits, and none of it may land
    lsu_rdata = take_bits(32);
    @(negedge clk);
    check_val("data_stall_o", data_stall, 1'b1);
    next_cycle();
    lsu_rvalid     = 1'b1;
    lsu_rdata      = take_bits(32);
    lsu_mpu_status = status;
    lsu_wpt_match  = wpt;
    wait_retire(cycles);
    check_val("abort_op_o", abort_op, 1'b1);
    next_cycle();
    lsu_rvalid     = 1'b0;
    lsu_mpu_status = MPU_OK;
    lsu_wpt_match  = 1'b0;
    check_reg(addr);
  endtask

  task automatic coproc_op(input logic exc);
    logic [`RADDR_W-1:0] addr;
    logic [`XLEN-1:0]    data;
    int                  cycles;
    addr = rand_addr();
    alu_write(addr, take_bits(32));
    data = take_bits(32);
    send_instr(1'b1, addr, take_bits(32), 1'b0, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_val("wb_valid_o", wb_valid, 1'b0);
      check_val("instr_ready_o", instr_ready, 1'b0);
      next_cycle();
    end
    xif_valid = 1'b1;
    xif_data  = data;
    xif_exc   = exc;
    next_cycle();
    xif_valid = 1'b0;
    wait_retire(cycles);
    check_val("coproc retire cycles", cycles, 0);
    next_cycle();
    if (!exc) begin
      exp_regs[addr] = data;
    end
    check_reg(addr);
  endtask

  task automatic test_kill();
    logic [`RADDR_W-1:0] addr;
    addr = rand_addr();
    alu_write(addr, take_bits(32));
    send_instr(1'b1, addr, take_bits(32), 1'b0, 1'b0);
    kill = 1'b1;
    @(negedge clk);
    check_val("wb_valid_o", wb_valid, 1'b0);
    next_cycle();
    kill = 1'b0;
    @(negedge clk);
    check_val("wb_valid_o", wb_valid, 1'b0);
    next_cycle();
    check_reg(addr);
    alu_write(addr, take_bits(32));
  endtask

  // Watchdog for a DUT that never answers
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("The run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    {instr_valid, instr_rf_we, instr_lsu_en, instr_xif_en, instr_last_op} = '0;
    {kill, halt, halt_limited, lsu_rvalid, lsu_wpt_match, xif_valid, xif_exc} = '0;
    instr_rf_waddr = '0;
    instr_rf_wdata = '0;
    lsu_rdata      = '0;
    lsu_mpu_status = MPU_OK;
    xif_data       = '0;
    rf_raddr       = '0;
    for (int i = 0; i < `NREGS; i++) begin
      exp_regs[i] = '0;
    end
    @(posedge rst_n);
    test_alu();
    test_load();
    faulty_load(MPU_RE_FAULT, 1'b0);
    faulty_load(MPU_WR_FAULT, 1'b0);
    faulty_load(MPU_OK, 1'b1);
    coproc_op(1'b0);
    coproc_op(1'b1);
    test_kill();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/core_types_pkg.sv
`default_nettype none

`include "wb_macros.svh"

package core_types_pkg;

  ////////////////////////////////////////////////////////////
  // Register file addressing
  ////////////////////////////////////////////////////////////

  // Index of one architectural register
  typedef logic [`RADDR_W-1:0] rf_addr_t;

  ////////////////////////////////////////////////////////////
  // EX/WB pipeline payload
  ////////////////////////////////////////////////////////////

  // Everything the write-back stage needs to know about one instruction
  // Validity is not part of the payload, it travels on the handshake
  typedef struct packed {
    logic              rf_we;     // Instruction writes a register
    rf_addr_t          rf_waddr;  // Destination register
    logic [`XLEN-1:0]  rf_wdata;  // ALU result computed in EX
    logic              lsu_en;    // Load or store
    logic              xif_en;    // Offloaded to the coprocessor
    logic              last_op;   // Last operation of the instruction
  } ex_wb_pipe_t;

  ////////////////////////////////////////////////////////////
  // Controller commands
  ////////////////////////////////////////////////////////////

  // The limited halt behaves like a normal halt inside WB
  typedef struct packed {
    logic kill_wb;          // Drop the WB instruction without side effects
    logic halt_wb;          // Hold the WB instruction in place
    logic halt_limited_wb;  // Halt used while the core is asleep
  } ctrl_t;

endpackage

`default_nettype wire

//--- source/lsu_resp_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// Response path from the LSU into the write-back stage
interface lsu_resp_if;

  import lsu_types_pkg::*;

  // Driven by the LSU side
  logic              rvalid;      // Response for the outstanding request
  logic [`XLEN-1:0]  rdata;       // Load data
  mpu_status_e       mpu_status;  // Protection check result
  logic              wpt_match;   // Watchpoint hit on this access

  // Driven by the stage side
  logic              lsu_valid;   // WB holds a request that waits for its response
  logic              lsu_ready;   // WB can take the response

  // The write-back stage consumes the response
  modport stage (
    input  rvalid, rdata, mpu_status, wpt_match,
    output lsu_valid, lsu_ready
  );

  // The LSU produces the response
  modport lsu (
    output rvalid, rdata, mpu_status, wpt_match,
    input  lsu_valid, lsu_ready
  );

endinterface

`default_nettype wire

//--- source/lsu_types_pkg.sv
`default_nettype none

`include "wb_macros.svh"

package lsu_types_pkg;

  ////////////////////////////////////////////////////////////
  // Memory protection status
  ////////////////////////////////////////////////////////////

  // Result of the protection check that travels with a load or store
  // The fourth encoding is unused
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  ////////////////////////////////////////////////////////////
  // Coprocessor result
  ////////////////////////////////////////////////////////////

  // Data returned by the coprocessor plus its synchronous exception flag
  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic             exc;
  } xif_result_t;

endpackage

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// Integer register file with one write and one combinational read port
module reg_file (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  core_types_pkg::rf_addr_t waddr_i,
  input  logic [`XLEN-1:0]         wdata_i,
  input  core_types_pkg::rf_addr_t raddr_i,
  output logic [`XLEN-1:0]         rdata_o
);

  logic [`XLEN-1:0] regs [`NREGS];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Every register starts at zero after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != `RADDR_W'(`REG_ZERO))) begin
      // x0 keeps its zero value whatever is written to it
      regs[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // The read is combinational so a write shows up right after its edge
  always_comb begin
    if (raddr_i == `RADDR_W'(`REG_ZERO)) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- source/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One-entry valid/ready buffer for any payload type
module stage_reg #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_i,
  output logic     ready_o,
  input  PAYLOAD_T data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output PAYLOAD_T data_o,
  input  logic     flush_i
);

  logic     valid_q;
  PAYLOAD_T data_q;

  // The slot is free when it is empty, when its item leaves now,
  // or when the held item is being thrown away
  assign ready_o = !valid_q || ready_i || flush_i;

  // Occupancy follows the upstream valid whenever the slot can take a new item
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only changes on an accepted transfer
  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // A stalled item must not change under the consumer
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_i |=> $stable(data_o)
  );

endmodule

`default_nettype wire

//--- source/wb_macros.svh
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

////////////////////////////////////////////////////////////
// Core data path dimensions
////////////////////////////////////////////////////////////

// Width of a register and of every data word in the back end
`define XLEN 32

// Number of architectural integer registers
`define NREGS 32

// Address width needed to select one of the NREGS registers
`define RADDR_W 5

// Register x0 is hardwired to zero and never written
`define REG_ZERO 0

// All three values must agree with each other
// NREGS is expected to equal 2 ** RADDR_W

`endif

//--- source/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// Write-back stage that retires one instruction from the EX/WB register
module wb_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pipe_valid_i,
  input  core_types_pkg::ex_wb_pipe_t pipe_i,
  input  core_types_pkg::ctrl_t      ctrl_i,
  lsu_resp_if.stage                  lsu,
  input  logic                       xif_valid_i,
  input  lsu_types_pkg::xif_result_t xif_i,
  output logic                       xif_ready_o,
  output logic                       rf_we_o,
  output core_types_pkg::rf_addr_t   rf_waddr_o,
  output logic [`XLEN-1:0]           rf_wdata_o,
  output logic                       wb_ready_o,
  output logic                       wb_valid_o,
  output logic                       abort_op_o,
  output logic                       data_stall_o,
  output logic                       last_op_o,
  output logic                       wpt_match_wb_o,
  output lsu_types_pkg::mpu_status_e mpu_status_wb_o
);

  import lsu_types_pkg::*;

  logic             halted;
  logic             instr_valid;
  logic             wb_valid;
  logic             lsu_waiting;
  logic             lsu_exception;
  logic             xif_waiting;
  logic             xif_exception;

  // Sticky copies of the late LSU response
  logic             lsu_valid_q;
  logic             lsu_wpt_match_q;
  mpu_status_e      lsu_mpu_status_q;
  logic [`XLEN-1:0] lsu_rdata_q;

  // Response as seen by WB, either live or from the sticky flops
  logic             lsu_valid;
  logic             lsu_wpt_match;
  mpu_status_e      lsu_mpu_status;
  logic [`XLEN-1:0] lsu_rdata;

  ////////////////////////////////////////////////////////////
  // Instruction state
  ////////////////////////////////////////////////////////////

  // Both halt flavours stop retirement in the same way
  assign halted      = ctrl_i.halt_wb || ctrl_i.halt_limited_wb;
  assign instr_valid = pipe_valid_i && !ctrl_i.kill_wb && !halted;

  // A coprocessor instruction cannot finish before its result shows up
  assign xif_waiting   = pipe_valid_i && pipe_i.xif_en && !xif_valid_i;
  assign xif_exception = pipe_valid_i && pipe_i.xif_en && xif_valid_i && xif_i.exc;

  // A load or store waits for its response
  assign lsu_waiting   = pipe_valid_i && pipe_i.lsu_en && !lsu_valid;
  assign lsu_exception = (lsu_mpu_status != MPU_OK);

  ////////////////////////////////////////////////////////////
  // Sticky LSU response
  ////////////////////////////////////////////////////////////

  // Status and valid live here from the response until retirement or kill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q      <= 1'b0;
      lsu_wpt_match_q  <= 1'b0;
      lsu_mpu_status_q <= MPU_OK;
    end else if (wb_valid || ctrl_i.kill_wb) begin
      lsu_valid_q      <= 1'b0;
      lsu_wpt_match_q  <= 1'b0;
      lsu_mpu_status_q <= MPU_OK;
    end else if (lsu.rvalid) begin
      lsu_valid_q      <= 1'b1;
      lsu_wpt_match_q  <= lsu.wpt_match;
      lsu_mpu_status_q <= lsu.mpu_status;
    end
  end

  // A load held by a halt still needs its data when it finally retires
  always_ff @(posedge clk) begin
    if (lsu.rvalid && !lsu_valid_q) begin
      lsu_rdata_q <= lsu.rdata;
    end
  end

  // Live values only count while the LSU marks them valid
  assign lsu_valid      = lsu_valid_q || lsu.rvalid;
  assign lsu_wpt_match  = lsu_valid_q ? lsu_wpt_match_q : (lsu.rvalid && lsu.wpt_match);
  assign lsu_mpu_status = lsu_valid_q ? lsu_mpu_status_q :
                          (lsu.rvalid ? lsu.mpu_status : MPU_OK);
  assign lsu_rdata      = lsu_valid_q ? lsu_rdata_q : lsu.rdata;

  // The request stays outstanding until the first response arrives
  assign lsu.lsu_valid = pipe_valid_i && pipe_i.lsu_en && !lsu_valid_q;
  assign lsu.lsu_ready = 1'b1;

  ////////////////////////////////////////////////////////////
  // Register write
  ////////////////////////////////////////////////////////////

  // Any error, watchpoint or missing result cancels the write
  assign rf_we_o = pipe_i.rf_we && !lsu_exception && !lsu_wpt_match && !lsu_waiting &&
                   !xif_waiting && !xif_exception && instr_valid;
  assign rf_waddr_o = pipe_i.rf_waddr;

  // Load data wins over coprocessor data, which wins over the ALU result
  assign rf_wdata_o = pipe_i.lsu_en ? lsu_rdata  :
                      pipe_i.xif_en ? xif_i.data :
                      pipe_i.rf_wdata;

  ////////////////////////////////////////////////////////////
  // Handshake and status
  ////////////////////////////////////////////////////////////

  assign wb_valid = ((!pipe_i.lsu_en && !xif_waiting) || (pipe_i.lsu_en && lsu_valid)) &&
                    instr_valid;
  assign wb_valid_o = wb_valid;

  // Kill frees the stage at once and no stall reason applies then
  assign wb_ready_o = ctrl_i.kill_wb || (!halted && !xif_waiting && !lsu_waiting);

  // The buffered result is taken on retirement or dropped on kill
  assign xif_ready_o = pipe_valid_i && pipe_i.xif_en && (instr_valid || ctrl_i.kill_wb);

  assign abort_op_o      = pipe_valid_i && pipe_i.lsu_en && (lsu_exception || lsu_wpt_match);
  assign data_stall_o    = pipe_i.lsu_en && !lsu_valid && instr_valid;
  assign last_op_o       = pipe_valid_i && pipe_i.last_op;
  assign wpt_match_wb_o  = lsu_wpt_match;
  assign mpu_status_wb_o = lsu_mpu_status;

  // The register file only changes for an instruction that retires
  a_we_retires : assert property (@(posedge clk) disable iff (!rst_n) rf_we_o |-> wb_valid_o);

  // The LSU answers only a request that WB still holds open
  a_rvalid_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    lsu.rvalid |-> lsu.lsu_valid && lsu.lsu_ready
  );

endmodule

`default_nettype wire

//--- source/wb_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_macros.svh"

// Back end of the core with the EX/WB register, WB stage and register file
module wb_subsys_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_valid_i,
  output logic                       instr_ready_o,
  input  logic                       instr_rf_we_i,
  input  logic [`RADDR_W-1:0]        instr_rf_waddr_i,
  input  logic [`XLEN-1:0]           instr_rf_wdata_i,
  input  logic                       instr_lsu_en_i,
  input  logic                       instr_xif_en_i,
  input  logic                       instr_last_op_i,
  input  logic                       kill_i,
  input  logic                       halt_i,
  input  logic                       halt_limited_i,
  input  logic                       lsu_rvalid_i,
  input  logic [`XLEN-1:0]           lsu_rdata_i,
  input  lsu_types_pkg::mpu_status_e lsu_mpu_status_i,
  input  logic                       lsu_wpt_match_i,
  output logic                       lsu_req_o,
  input  logic                       xif_valid_i,
  output logic                       xif_ready_o,
  input  logic [`XLEN-1:0]           xif_data_i,
  input  logic                       xif_exc_i,
  input  logic [`RADDR_W-1:0]        rf_raddr_i,
  output logic [`XLEN-1:0]           rf_rdata_o,
  output logic                       wb_valid_o,
  output logic                       abort_op_o,
  output logic                       data_stall_o,
  output logic                       last_op_o
);

  import core_types_pkg::*;
  import lsu_types_pkg::*;

  ex_wb_pipe_t      ex_wb_in, ex_wb_pipe;
  ctrl_t            ctrl;
  xif_result_t      xif_in, xif_buf_data;
  logic             pipe_valid, wb_ready, xif_buf_valid, xif_result_ready;
  logic             rf_we;
  rf_addr_t         rf_waddr;
  logic [`XLEN-1:0] rf_wdata;

  lsu_resp_if lsu_resp ();

  ////////////////////////////////////////////////////////////
  // Port bundling
  ////////////////////////////////////////////////////////////

  assign ex_wb_in = '{rf_we: instr_rf_we_i, rf_waddr: instr_rf_waddr_i,
                      rf_wdata: instr_rf_wdata_i, lsu_en: instr_lsu_en_i,
                      xif_en: instr_xif_en_i, last_op: instr_last_op_i};
  assign ctrl     = '{kill_wb: kill_i, halt_wb: halt_i, halt_limited_wb: halt_limited_i};
  assign xif_in   = '{data: xif_data_i, exc: xif_exc_i};

  // LSU response comes in on plain ports
  assign lsu_resp.rvalid     = lsu_rvalid_i;
  assign lsu_resp.rdata      = lsu_rdata_i;
  assign lsu_resp.mpu_status = lsu_mpu_status_i;
  assign lsu_resp.wpt_match  = lsu_wpt_match_i;
  assign lsu_req_o           = lsu_resp.lsu_valid;

  // Kill empties the EX/WB slot
  stage_reg #(.PAYLOAD_T(ex_wb_pipe_t)) u_ex_wb (
    .clk, .rst_n, .valid_i(instr_valid_i), .ready_o(instr_ready_o), .data_i(ex_wb_in),
    .valid_o(pipe_valid), .ready_i(wb_ready), .data_o(ex_wb_pipe), .flush_i(kill_i)
  );

  // Coprocessor results wait here until WB asks for them
  stage_reg #(.PAYLOAD_T(xif_result_t)) u_xif_buf (
    .clk, .rst_n, .valid_i(xif_valid_i), .ready_o(xif_ready_o), .data_i(xif_in),
    .valid_o(xif_buf_valid), .ready_i(xif_result_ready), .data_o(xif_buf_data), .flush_i(1'b0)
  );

  wb_stage u_wb (
    .clk, .rst_n, .pipe_valid_i(pipe_valid), .pipe_i(ex_wb_pipe), .ctrl_i(ctrl),
    .lsu(lsu_resp.stage), .xif_valid_i(xif_buf_valid), .xif_i(xif_buf_data),
    .xif_ready_o(xif_result_ready), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr),
    .rf_wdata_o(rf_wdata), .wb_ready_o(wb_ready), .wb_valid_o, .abort_op_o, .data_stall_o,
    .last_op_o, .wpt_match_wb_o(), .mpu_status_wb_o()
  );

  reg_file u_rf (
    .clk, .rst_n, .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr_i(rf_raddr_i), .rdata_o(rf_rdata_o)
  );

endmodule

`default_nettype wire
